/* build.f */
logic/periph_pkg.sv
logic/axil_decode.sv
logic/irq_control.sv
logic/down_timer.sv
logic/acct_counters.sv
logic/read_result.sv
logic/cpu_periphs.sv
tests/cpu_periphs_props.sv
tests/cpu_periphs_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_periphs_tb \
	-f build.f --Mdir obj_dir -o cpu_periphs_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/cpu_periphs_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tests/cpu_periphs_tb.sv */
// Runs with EXT_INTS = 2 only; inputs change 1 unit after each rising edge, outputs read then
module cpu_periphs_tb import periph_pkg::*; ();

	localparam int EXT_INTS = 2;
	localparam int TIMEOUT  = 200;

	logic                S_AXI_ACLK;
	logic                cpu_reset;
	logic                awvalid, wvalid, bready, arvalid, rready;
	logic [ADDR_W-1:0]   awaddr, araddr;
	logic [DATA_W-1:0]   wdata, rdata;
	logic [STRB_W-1:0]   wstrb;
	logic                awready, wready, bvalid, arready, rvalid;
	logic [1:0]          bresp, rresp;
	cpu_status_t         cpu_status;
	logic [EXT_INTS-1:0] ivec;
	logic                interrupt, watchdog_reset;

	integer            seed;
	int                err_cnt;
	logic [DATA_W-1:0] model [8];

	cpu_periphs #(.EXT_INTS(EXT_INTS)) DUT (
		.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(cpu_reset),
		.S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready), .S_AXI_AWADDR(awaddr),
		.S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready), .S_AXI_WDATA(wdata),
		.S_AXI_WSTRB(wstrb), .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
		.S_AXI_BRESP(bresp), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
		.S_AXI_ARADDR(araddr), .S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
		.S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp), .i_cpu_status(cpu_status),
		.i_ivec(ivec), .o_interrupt(interrupt), .o_watchdog_reset(watchdog_reset)
	);

	always #5 S_AXI_ACLK = ~S_AXI_ACLK;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [DATA_W-1:0] next_rand();
		next_rand = $random(seed);
	endfunction

	// Expected word after a byte-strobed write
	function automatic logic [DATA_W-1:0] strobe_update(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] mask;
		for (int b = 0; b < STRB_W; b++)
			mask[8*b +: 8] = {8{strb[b]}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		if (got !== exp) begin
			err_cnt++;
			fail_run($sformatf("Mismatch at time %0t: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic next_cycle();
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	// One write with random BREADY stalls, exactly one response expected
	task automatic axil_write(input reg_addr_e reg_a, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
		int                waited;
		logic [DATA_W-1:0] r;
		r       = next_rand();
		awvalid = 1'b1;
		awaddr  = {reg_a, r[1:0]};
		wvalid  = 1'b1;
		wdata   = data;
		wstrb   = strb;
		bready  = r[2];
		waited  = 0;
		while (!awready) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT)
				fail_run("Timeout: the write was never accepted");
		end
		check_value(32'(wready), 32'h1, "WREADY together with AWREADY");
		// Transfer on the coming edge
		next_cycle();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		waited  = 0;
		while (!(bvalid && bready)) begin
			next_cycle();
			r      = next_rand();
			bready = r[0];
			waited++;
			if (waited > TIMEOUT)
				fail_run("Timeout: no write response arrived");
		end
		check_value(32'(bresp), 32'h0, "write response code");
		next_cycle();
		bready = 1'b0;
		check_value(32'(bvalid), 32'h0, "single write response");
	endtask

	task automatic axil_read(input reg_addr_e reg_a, output logic [DATA_W-1:0] data);
		int                waited;
		logic [DATA_W-1:0] r;
		r       = next_rand();
		arvalid = 1'b1;
		araddr  = {reg_a, r[1:0]};
		waited  = 0;
		while (!arready) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT)
				fail_run("Timeout: the read was never accepted");
		end
		next_cycle();
		arvalid = 1'b0;
		r       = next_rand();
		rready  = r[0];
		waited  = 0;
		while (!(rvalid && rready)) begin
			next_cycle();
			r      = next_rand();
			rready = r[0];
			waited++;
			if (waited > TIMEOUT)
				fail_run("Timeout: no read response arrived");
		end
		data = rdata;
		check_value(32'(rresp), 32'h0, "read response code");
		next_cycle();
		rready = 1'b0;
		check_value(32'(rvalid), 32'h0, "single read response");
	endtask

	task automatic read_expect(input reg_addr_e reg_a, input logic [DATA_W-1:0] exp,
		input string what);
		logic [DATA_W-1:0] got;
		axil_read(reg_a, got);
		check_value(got, exp, what);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic [DATA_W-1:0] got, base, wd, r;
		reg_addr_e         ra;
		int                pulses, waited, bit_i;
		seed       = 32'h44313d8e;
		err_cnt    = 0;
		S_AXI_ACLK = 1'b0;
		cpu_reset  = 1'b1;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		cpu_status = '{halted: 1'b1, gie: 1'b0, icount: 1'b0};
		ivec       = '0;
		for (int k = 0; k < 8; k++)
			model[k] = '0;
		repeat (4) @(posedge S_AXI_ACLK);
		#1;
		cpu_reset = 1'b0;

		// Reset state, everything reads zero while halted
		check_value(32'(awready), 32'h0, "AWREADY after reset");
		check_value(32'(wready), 32'h0, "WREADY after reset");
		check_value(32'(bvalid), 32'h0, "BVALID after reset");
		check_value(32'(rvalid), 32'h0, "RVALID after reset");
		check_value(32'(interrupt), 32'h0, "interrupt after reset");
		check_value(32'(watchdog_reset), 32'h0, "watchdog reset after reset");
		for (int k = 0; k < 8; k++)
			read_expect(reg_addr_e'(k[2:0]), model[k], "register after reset");

		// Strobed counter writes, with the reserved word mixed in
		repeat (24) begin
			r  = next_rand();
			wd = next_rand();
			ra = reg_addr_e'({1'b1, r[1:0]});
			if (r[5:3] == 3'd0)
				ra = REG_RESERVED;
			else
				model[ra] = strobe_update(model[ra], wd, r[11:8]);
			axil_write(ra, wd, r[11:8]);
			read_expect(ra, model[ra], "counter read-back");
		end

		// Supervisor counting, user counters hold while gie is low
		cpu_status.halted = 1'b0;
		axil_read(REG_M_CLOCKS, base);
		axil_read(REG_M_ICOUNT, wd);
		pulses = 0;
		repeat (50) begin
			r = next_rand();
			cpu_status.icount = r[0];
			if (r[0])
				pulses++;
			next_cycle();
		end
		cpu_status.icount = 1'b0;
		axil_read(REG_M_CLOCKS, got);
		check_value(32'(got - base >= 50), 32'h1, "supervisor clocks advance");
		axil_read(REG_M_ICOUNT, got);
		check_value(got - wd, pulses, "supervisor instruction count");
		read_expect(REG_U_CLOCKS, model[REG_U_CLOCKS], "user clocks with gie low");
		read_expect(REG_U_ICOUNT, model[REG_U_ICOUNT], "user icount with gie low");
		cpu_status.gie = 1'b1;
		axil_read(REG_U_CLOCKS, base);
		repeat (40) next_cycle();
		axil_read(REG_U_CLOCKS, got);
		check_value(32'(got - base >= 40), 32'h1, "user clocks advance with gie");
		cpu_status = '{halted: 1'b1, gie: 1'b0, icount: 1'b0};

		// Interval timer drives PIC source 0
		axil_write(REG_PIC, 32'h8001_0000, 4'hf);
		r  = next_rand();
		wd = 32'(r[3:0]) + 32'd4;
		axil_write(REG_TIMER, wd, 4'hf);
		read_expect(REG_TIMER, wd, "timer load while halted");
		check_value(32'(interrupt), 32'h0, "interrupt before timer expiry");
		cpu_status.halted = 1'b0;
		waited = 0;
		while (!interrupt) begin
			next_cycle();
			waited++;
			if (waited > 20 + wd)
				fail_run("Timeout: the timer interrupt never arrived");
		end
		cpu_status.halted = 1'b1;
		read_expect(REG_PIC, 32'h8001_0001, "PIC status after timer expiry");
		read_expect(REG_TIMER, 32'h0, "timer after expiry without reload");
		axil_write(REG_PIC, 32'h8001_0001, 4'hf);
		check_value(32'(interrupt), 32'h0, "interrupt after status clear");
		read_expect(REG_PIC, 32'h8001_0000, "PIC after status clear");

		// External source, needs both its enable and the master enable
		axil_write(REG_PIC, 32'h0000_7fff, 4'hf);
		read_expect(REG_PIC, 32'h0, "PIC cleared");
		r     = next_rand();
		bit_i = int'(r[7:0]) % EXT_INTS;
		ivec[bit_i] = 1'b1;
		next_cycle();
		ivec = '0;
		read_expect(REG_PIC, 32'(1) << (bit_i + 1), "external status latch");
		check_value(32'(interrupt), 32'h0, "interrupt with all enables off");
		axil_write(REG_PIC, 32'(1) << (bit_i + 17), 4'hf);
		check_value(32'(interrupt), 32'h0, "interrupt without master enable");
		axil_write(REG_PIC, 32'h8001_0000, 4'hf);
		check_value(32'(interrupt), 32'h0, "interrupt with source masked");
		axil_write(REG_PIC, 32'h8000_0000 | (32'(1) << (bit_i + 17)), 4'hf);
		check_value(32'(interrupt), 32'h1, "interrupt with both enables");
		axil_write(REG_PIC, 32'h0000_7fff, 4'hf);
		check_value(32'(interrupt), 32'h0, "interrupt after full clear");

		// Watchdog, bit 31 is dropped on write
		r  = next_rand();
		wd = {r[31], 26'd0, r[4:0]} + 32'd8;
		axil_write(REG_WATCHDOG, wd, 4'hf);
		read_expect(REG_WATCHDOG, wd & 32'h7fff_ffff, "watchdog load while halted");
		check_value(32'(watchdog_reset), 32'h0, "watchdog reset while halted");
		cpu_status.halted = 1'b0;
		waited = 0;
		while (!watchdog_reset) begin
			next_cycle();
			waited++;
			if (waited > (wd & 32'h7fff_ffff) + 10)
				fail_run("Timeout: the watchdog reset never pulsed");
		end
		next_cycle();
		check_value(32'(watchdog_reset), 32'h0, "watchdog reset pulse width");
		cpu_status.halted = 1'b1;
		read_expect(REG_WATCHDOG, 32'h0, "watchdog after expiry");

		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* tests/cpu_periphs_props.sv */
// Bound into cpu_periphs; covers response stability and watchdog pulse width, not data values
module cpu_periphs_props import periph_pkg::*; (
	input logic              S_AXI_ACLK,
	input logic              i_cpu_reset,
	input logic              S_AXI_ARREADY,
	input logic              S_AXI_RVALID,
	input logic              S_AXI_RREADY,
	input logic [DATA_W-1:0] S_AXI_RDATA,
	input logic              S_AXI_BVALID,
	input logic              S_AXI_BREADY,
	input logic              o_watchdog_reset
);

	// No new read while a read response is stalled
	a_ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		(S_AXI_RVALID && !S_AXI_RREADY) |-> !S_AXI_ARREADY)
		else $error("ARREADY high while the read response is stalled");

	a_r_stable: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		(S_AXI_RVALID && !S_AXI_RREADY) |=> (S_AXI_RVALID && $stable(S_AXI_RDATA)))
		else $error("RVALID or RDATA changed before RREADY");

	a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		(S_AXI_BVALID && !S_AXI_BREADY) |=> S_AXI_BVALID)
		else $error("BVALID dropped before BREADY");

	// Reset request is a single-cycle pulse
	a_wdog_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (i_cpu_reset)
		o_watchdog_reset |=> !o_watchdog_reset)
		else $error("Watchdog reset held for two cycles");

endmodule

bind cpu_periphs cpu_periphs_props u_props (
	.S_AXI_ACLK(S_AXI_ACLK), .i_cpu_reset(i_cpu_reset), .S_AXI_ARREADY(S_AXI_ARREADY),
	.S_AXI_RVALID(S_AXI_RVALID), .S_AXI_RREADY(S_AXI_RREADY), .S_AXI_RDATA(S_AXI_RDATA),
	.S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
	.o_watchdog_reset(o_watchdog_reset)
);

/* logic/cpu_periphs.sv */
// One reset clears the bus and the peripherals; EXT_INTS must be 1 to 14, timer is source 0
module cpu_periphs import periph_pkg::*; #(
	parameter int EXT_INTS = 2
) (
	input  logic                S_AXI_ACLK,
	input  logic                i_cpu_reset,
	input  logic                S_AXI_AWVALID,
	output logic                S_AXI_AWREADY,
	input  logic [ADDR_W-1:0]   S_AXI_AWADDR,
	input  logic                S_AXI_WVALID,
	output logic                S_AXI_WREADY,
	input  logic [DATA_W-1:0]   S_AXI_WDATA,
	input  logic [STRB_W-1:0]   S_AXI_WSTRB,
	output logic                S_AXI_BVALID,
	input  logic                S_AXI_BREADY,
	output logic [1:0]          S_AXI_BRESP,
	input  logic                S_AXI_ARVALID,
	output logic                S_AXI_ARREADY,
	input  logic [ADDR_W-1:0]   S_AXI_ARADDR,
	output logic                S_AXI_RVALID,
	input  logic                S_AXI_RREADY,
	output logic [DATA_W-1:0]   S_AXI_RDATA,
	output logic [1:0]          S_AXI_RRESP,
	input  cpu_status_t         i_cpu_status,
	input  logic [EXT_INTS-1:0] i_ivec,
	output logic                o_interrupt,
	output logic                o_watchdog_reset
);

	wr_cmd_t           wr_cmd;
	reg_addr_e         rd_addr;
	logic              rd_stb, wr_busy, rd_busy, timer_int;
	logic [DATA_W-1:0] pic_data, wdog_data, timer_data;
	logic [DATA_W-1:0] m_clocks, m_icount, u_clocks, u_icount;

	//////////////////////////////
	// Decode
	//////////////////////////////

	axil_decode u_decode (
		.S_AXI_ACLK, .i_cpu_reset,
		.i_awvalid(S_AXI_AWVALID), .i_awaddr(S_AXI_AWADDR),
		.i_wvalid(S_AXI_WVALID), .i_wdata(S_AXI_WDATA), .i_wstrb(S_AXI_WSTRB),
		.i_arvalid(S_AXI_ARVALID), .i_araddr(S_AXI_ARADDR),
		.i_wr_busy(wr_busy), .i_rd_busy(rd_busy),
		.o_awready(S_AXI_AWREADY), .o_wready(S_AXI_WREADY), .o_arready(S_AXI_ARREADY),
		.o_wr_cmd(wr_cmd), .o_rd_stb(rd_stb), .o_rd_addr(rd_addr)
	);

	//////////////////////////////
	// Execute
	//////////////////////////////

	irq_control #(.EXT_INTS(EXT_INTS)) u_pic (
		.S_AXI_ACLK, .i_cpu_reset, .i_wr_cmd(wr_cmd),
		.i_sources({i_ivec, timer_int}),
		.o_data(pic_data), .o_interrupt(o_interrupt)
	);

	down_timer #(.OPT_RELOAD(1'b1), .REG_SEL(REG_TIMER)) u_timer (
		.S_AXI_ACLK, .i_cpu_reset, .i_wr_cmd(wr_cmd), .i_cpu_status,
		.o_data(timer_data), .o_expired(timer_int)
	);

	// Watchdog never reloads
	down_timer #(.OPT_RELOAD(1'b0), .REG_SEL(REG_WATCHDOG)) u_watchdog (
		.S_AXI_ACLK, .i_cpu_reset, .i_wr_cmd(wr_cmd), .i_cpu_status,
		.o_data(wdog_data), .o_expired(o_watchdog_reset)
	);

	acct_counters u_counters (
		.S_AXI_ACLK, .i_cpu_reset, .i_wr_cmd(wr_cmd), .i_cpu_status,
		.o_m_clocks(m_clocks), .o_m_icount(m_icount),
		.o_u_clocks(u_clocks), .o_u_icount(u_icount)
	);

	//////////////////////////////
	// Result
	//////////////////////////////

	read_result u_result (
		.S_AXI_ACLK, .i_cpu_reset, .i_rd_stb(rd_stb), .i_rd_addr(rd_addr),
		.i_wr_cmd(wr_cmd), .i_pic_data(pic_data), .i_wdog_data(wdog_data),
		.i_timer_data(timer_data), .i_m_clocks(m_clocks), .i_m_icount(m_icount),
		.i_u_clocks(u_clocks), .i_u_icount(u_icount),
		.S_AXI_BREADY, .S_AXI_RREADY,
		.o_bvalid(S_AXI_BVALID), .o_rvalid(S_AXI_RVALID), .o_rdata(S_AXI_RDATA),
		.o_wr_busy(wr_busy), .o_rd_busy(rd_busy)
	);

	// OKAY on every response
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

endmodule

/* logic/read_result.sv */
// Responses are always OKAY; RDATA is only meaningful while RVALID is high
module read_result import periph_pkg::*; (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	input  logic              i_rd_stb,
	input  reg_addr_e         i_rd_addr,
	input  wr_cmd_t           i_wr_cmd,
	input  logic [DATA_W-1:0] i_pic_data,
	input  logic [DATA_W-1:0] i_wdog_data,
	input  logic [DATA_W-1:0] i_timer_data,
	input  logic [DATA_W-1:0] i_m_clocks,
	input  logic [DATA_W-1:0] i_m_icount,
	input  logic [DATA_W-1:0] i_u_clocks,
	input  logic [DATA_W-1:0] i_u_icount,
	input  logic              S_AXI_BREADY,
	input  logic              S_AXI_RREADY,
	output logic              o_bvalid,
	output logic              o_rvalid,
	output logic [DATA_W-1:0] o_rdata,
	output logic              o_wr_busy,
	output logic              o_rd_busy
);

	logic [DATA_W-1:0] rd_word;

	always_comb begin
		case (i_rd_addr)
		REG_PIC:      rd_word = i_pic_data;
		REG_WATCHDOG: rd_word = i_wdog_data;
		REG_TIMER:    rd_word = i_timer_data;
		REG_M_CLOCKS: rd_word = i_m_clocks;
		REG_M_ICOUNT: rd_word = i_m_icount;
		REG_U_CLOCKS: rd_word = i_u_clocks;
		REG_U_ICOUNT: rd_word = i_u_icount;
		default:      rd_word = '0;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset) begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			if (i_wr_cmd.valid)
				o_bvalid <= 1'b1;
			else if (S_AXI_BREADY)
				o_bvalid <= 1'b0;
			if (i_rd_stb)
				o_rvalid <= 1'b1;
			else if (S_AXI_RREADY)
				o_rvalid <= 1'b0;
		end
	end

	// Data is captured only on an accepted read
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_rd_stb)
			o_rdata <= rd_word;
	end

	assign o_wr_busy = o_bvalid && !S_AXI_BREADY;
	assign o_rd_busy = o_rvalid && !S_AXI_RREADY;

endmodule

/* logic/acct_counters.sv */
// Counters wrap at 2^32; a bus write to a counter overrides its count in that cycle
module acct_counters import periph_pkg::*; (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	input  wr_cmd_t           i_wr_cmd,
	input  cpu_status_t       i_cpu_status,
	output logic [DATA_W-1:0] o_m_clocks,
	output logic [DATA_W-1:0] o_m_icount,
	output logic [DATA_W-1:0] o_u_clocks,
	output logic [DATA_W-1:0] o_u_icount
);

	localparam reg_addr_e CNT_ADDR [4] = '{REG_M_CLOCKS, REG_M_ICOUNT,
		REG_U_CLOCKS, REG_U_ICOUNT};

	logic [3:0]        inc;
	logic [DATA_W-1:0] cnt [4];

	// Count events, index order follows CNT_ADDR
	assign inc[0] = !i_cpu_status.halted;
	assign inc[1] = i_cpu_status.icount;
	assign inc[2] = !i_cpu_status.halted && i_cpu_status.gie;
	assign inc[3] = i_cpu_status.icount && i_cpu_status.gie;

	for (genvar k = 0; k < 4; k++) begin : g_cnt
		logic sel_wr;

		assign sel_wr = i_wr_cmd.valid && (i_wr_cmd.addr == CNT_ADDR[k]);

		always_ff @(posedge S_AXI_ACLK) begin
			if (i_cpu_reset)
				cnt[k] <= '0;
			else if (sel_wr)
				cnt[k] <= merge_wstrb(cnt[k], i_wr_cmd.data, i_wr_cmd.strb);
			else if (inc[k])
				cnt[k] <= cnt[k] + 1'b1;
		end
	end

	assign o_m_clocks = cnt[0];
	assign o_m_icount = cnt[1];
	assign o_u_clocks = cnt[2];
	assign o_u_icount = cnt[3];

endmodule

/* logic/down_timer.sv */
// Counts only while the CPU runs; a zero count is idle, and without reload bit 31 reads zero
module down_timer import periph_pkg::*; #(
	parameter bit        OPT_RELOAD = 1'b1,
	parameter reg_addr_e REG_SEL    = REG_TIMER
) (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	input  wr_cmd_t           i_wr_cmd,
	input  cpu_status_t       i_cpu_status,
	output logic [DATA_W-1:0] o_data,
	output logic              o_expired
);

	logic [30:0]       count;
	logic [30:0]       reload_val;
	logic              reload_en;
	logic              sel_wr;
	logic [DATA_W-1:0] merged;

	assign sel_wr = i_wr_cmd.valid && (i_wr_cmd.addr == REG_SEL);
	assign merged = merge_wstrb(o_data, i_wr_cmd.data, i_wr_cmd.strb);

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset) begin
			count     <= '0;
			reload_en <= 1'b0;
			o_expired <= 1'b0;
		end else begin
			o_expired <= 1'b0;
			if (sel_wr) begin
				count     <= merged[30:0];
				reload_en <= OPT_RELOAD && merged[31];
			end else if (!i_cpu_status.halted && (count != '0)) begin
				if (count == 31'd1) begin
					o_expired <= 1'b1;
					count     <= reload_en ? reload_val : '0;
				end else begin
					count <= count - 31'd1;
				end
			end
		end
	end

	// Start value kept for auto-reload
	always_ff @(posedge S_AXI_ACLK) begin
		if (sel_wr)
			reload_val <= merged[30:0];
	end

	assign o_data = {reload_en, count};

endmodule

/* logic/irq_control.sv */
// Up to 15 sources; writing 1 to a status bit clears it, and bit 15 always reads zero
module irq_control import periph_pkg::*; #(
	parameter int EXT_INTS = 2
) (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	input  wr_cmd_t           i_wr_cmd,
	input  logic [EXT_INTS:0] i_sources,
	output logic [DATA_W-1:0] o_data,
	output logic              o_interrupt
);

	localparam int NSRC = 15;

	logic [NSRC-1:0]   status;
	logic [NSRC-1:0]   enable;
	logic              master_en;
	logic [NSRC-1:0]   src_vec;
	logic [DATA_W-1:0] merged;
	logic              pic_wr;

	// Unused source slots stay zero
	assign src_vec = NSRC'(i_sources);

	assign pic_wr = i_wr_cmd.valid && (i_wr_cmd.addr == REG_PIC);
	assign merged = merge_wstrb(o_data, i_wr_cmd.data, i_wr_cmd.strb);

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset) begin
			status    <= '0;
			enable    <= '0;
			master_en <= 1'b0;
		end else if (pic_wr) begin
			// New pulses win over a clear in the same cycle
			status    <= (status & ~merged[NSRC-1:0]) | src_vec;
			enable    <= merged[30:16];
			master_en <= merged[31];
		end else begin
			status    <= status | src_vec;
		end
	end

	assign o_data = {master_en, enable, 1'b0, status};

	// Any enabled pending source, gated by the master enable
	assign o_interrupt = master_en && |(status & enable);

endmodule

/* logic/axil_decode.sv */
// Single-beat AXI-lite only; AW and W must both be valid before a write is taken, no PROT
module axil_decode import periph_pkg::*; (
	input  logic              S_AXI_ACLK,
	input  logic              i_cpu_reset,
	// Write address and data channels
	input  logic              i_awvalid,
	input  logic [ADDR_W-1:0] i_awaddr,
	input  logic              i_wvalid,
	input  logic [DATA_W-1:0] i_wdata,
	input  logic [STRB_W-1:0] i_wstrb,
	// Read address channel
	input  logic              i_arvalid,
	input  logic [ADDR_W-1:0] i_araddr,
	// Response back-pressure
	input  logic              i_wr_busy,
	input  logic              i_rd_busy,
	output logic              o_awready,
	output logic              o_wready,
	output logic              o_arready,
	output wr_cmd_t           o_wr_cmd,
	output logic              o_rd_stb,
	output reg_addr_e         o_rd_addr
);

	//////////////////////////////
	// Write acceptance
	//////////////////////////////

	logic wr_ready;

	// Shared AW/W ready, high for one cycle per write
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_cpu_reset)
			wr_ready <= 1'b0;
		else
			wr_ready <= !wr_ready && i_awvalid && i_wvalid && !i_wr_busy;
	end

	assign o_awready = wr_ready;
	assign o_wready  = wr_ready;

	// Transfer happens while ready is high
	always_comb begin
		o_wr_cmd.valid = wr_ready;
		o_wr_cmd.addr  = reg_addr_e'(i_awaddr[ADDR_W-1:2]);
		o_wr_cmd.data  = i_wdata;
		o_wr_cmd.strb  = i_wstrb;
	end

	//////////////////////////////
	// Read acceptance
	//////////////////////////////

	// Ready unless a read response is stalled
	assign o_arready = !i_rd_busy;
	assign o_rd_stb  = i_arvalid && !i_rd_busy;

	// Byte offset within the word is ignored
	assign o_rd_addr = reg_addr_e'(i_araddr[ADDR_W-1:2]);

endmodule

/* logic/periph_pkg.sv */
// Register map assumes 32-bit words at byte address bits 4:2; only eight registers exist
package periph_pkg;

	localparam int ADDR_W = 5;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Word index of each register
	typedef enum logic [2:0] {
		REG_PIC      = 3'd0,
		REG_WATCHDOG = 3'd1,
		REG_TIMER    = 3'd2,
		REG_RESERVED = 3'd3,
		REG_M_CLOCKS = 3'd4,
		REG_M_ICOUNT = 3'd5,
		REG_U_CLOCKS = 3'd6,
		REG_U_ICOUNT = 3'd7
	} reg_addr_e;

	// One accepted write, present for a single cycle
	typedef struct packed {
		logic                valid;
		reg_addr_e           addr;
		logic [DATA_W-1:0]   data;
		logic [STRB_W-1:0]   strb;
	} wr_cmd_t;

	// CPU state seen by the peripherals
	typedef struct packed {
		logic halted;
		logic gie;
		logic icount;
	} cpu_status_t;

	// Replace each byte of the old word whose strobe is set
	function automatic logic [DATA_W-1:0] merge_wstrb(input logic [DATA_W-1:0] old_word,
		input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] result;
		result = old_word;
		for (int k = 0; k < STRB_W; k++) begin
			if (strb[k])
				result[8*k +: 8] = new_word[8*k +: 8];
		end
		return result;
	endfunction

endpackage
